//--- hdl/fdc_macros.svh
// ========================================
// floppy controller constants
// register addresses, command timing and
// the widths shared by the controller blocks
// ========================================
`ifndef FDC_MACROS_SVH
`define FDC_MACROS_SVH

// host register addresses
// status reads and command writes share address 0
`define FDC_A_CMD     2'd0
`define FDC_A_TRACK   2'd1
`define FDC_A_SECTOR  2'd2
`define FDC_A_DATA    2'd3

// ========================================
// timing in clk_sys cycles
// ========================================
`define FDC_SETTLE_CYCLES  64   // type I busy time, also write fault
`define FDC_SEARCH_CYCLES  16   // sector search before range check
`define FDC_BYTE_GAP       15   // wait before each drq

// widths
`define FDC_DLY_W   7    // delay counter, holds the settle time
`define FDC_IMG_AW  20   // image address, 1 MB max
`define FDC_LEN_W   11   // sector length and byte index

`endif

//--- hdl/fdc_pkg.sv
// ========================================
// floppy controller types
// status word views and engine states
// ========================================
package fdc_pkg;

	// status as seen after restore, seek, step, force interrupt
	typedef struct packed {
		logic not_ready;
		logic write_prot;
		logic head_loaded;
		logic seek_err;
		logic crc_err;
		logic track0;
		logic index;
		logic busy;
	} fdc_status_type1_t;

	// status as seen after read or write sector
	typedef struct packed {
		logic not_ready;
		logic write_prot;
		logic write_fault;
		logic rec_not_found;
		logic crc_err;
		logic lost_data;
		logic drq;
		logic busy;
	} fdc_status_type2_t;

	// one byte, decoded by the class of the last command
	typedef union packed {
		fdc_status_type1_t t1;
		fdc_status_type2_t t2;
	} fdc_status_u;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SETTLE,   // type I and write fault delay
		ST_SEARCH,   // sector search
		ST_GAP,      // wait before drq
		ST_DRQ,      // byte offered to host
		ST_ABORT,
		ST_END
	} fdc_state_e;

endpackage

//--- hdl/fdc_geometry.sv
// ========================================
// disk image geometry
// maps head track, side, sector and byte
// index to a flat image byte address for
// the five fixed track layouts
// ========================================
`timescale 1ns/1ns
`include "fdc_macros.svh"

module fdc_geometry (
	input  logic [2:0]               size_code,
	input  logic [7:0]               head_track,
	input  logic                     side,
	input  logic [7:0]               sector,
	input  logic [`FDC_LEN_W-1:0]    byte_index,
	output logic [`FDC_IMG_AW-1:0]   buff_addr,
	output logic [7:0]               sectors_per_track,
	output logic [`FDC_LEN_W-1:0]    sector_bytes
);

	logic [13:0]              lt;         // logical track, zero extended
	logic [13:0]              lin;        // linear sector number on the image
	logic [1:0]               len_code;   // 128 << len_code bytes per sector
	logic [`FDC_IMG_AW-1:0]   base;

	always_comb begin
		lt = {5'd0, head_track, side};
		case (size_code)
			3'd1: begin   // 16 x 256
				sectors_per_track = 8'd16;
				len_code = 2'd1;
				lin = lt << 4;
			end
			3'd2: begin   // 9 x 512
				sectors_per_track = 8'd9;
				len_code = 2'd2;
				lin = (lt << 3) + lt;
			end
			3'd3: begin   // 5 x 1024
				sectors_per_track = 8'd5;
				len_code = 2'd3;
				lin = (lt << 2) + lt;
			end
			3'd4: begin   // 10 x 512
				sectors_per_track = 8'd10;
				len_code = 2'd2;
				lin = (lt << 3) + (lt << 1);
			end
			default: begin   // 26 x 128, also codes 5 to 7
				sectors_per_track = 8'd26;
				len_code = 2'd0;
				lin = (lt << 4) + (lt << 3) + (lt << 1);
			end
		endcase

		// sectors are numbered from 1
		lin = lin + {6'd0, sector} - 14'd1;
		base = {6'd0, lin} << (4'd7 + {2'd0, len_code});
		buff_addr = base + {9'd0, byte_index};
		sector_bytes = 11'd128 << len_code;
	end

endmodule

//--- hdl/fdc_regs.sv
// ========================================
// host register file
// track, sector and data registers, access
// strobes and the read data multiplexer
// ========================================
`timescale 1ns/1ns
`include "fdc_macros.svh"

module fdc_regs (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               rd,
	input  logic               wr,
	input  logic [1:0]         addr,
	input  logic [7:0]         din,
	input  logic               busy,
	input  fdc_pkg::fdc_status_u status,
	input  logic               xfer,
	input  logic [7:0]         buff_din,
	input  logic               track_set,
	input  logic [7:0]         track_value,
	input  logic               sector_inc,
	output logic [7:0]         dout,
	output logic               cmd_wr,
	output logic               status_rd,
	output logic               data_rd,
	output logic [7:0]         track_reg,
	output logic [7:0]         sector_reg,
	output logic [7:0]         data_reg
);

	// one-cycle strobes for the engine
	assign cmd_wr    = wr && (addr == `FDC_A_CMD);
	assign status_rd = rd && (addr == `FDC_A_CMD);
	assign data_rd   = rd && (addr == `FDC_A_DATA);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			track_reg  <= 8'd0;
			sector_reg <= 8'd0;
			data_reg   <= 8'd0;
		end else begin
			// engine updates take priority over the host
			if (track_set)
				track_reg <= track_value;
			else if (wr && (addr == `FDC_A_TRACK) && !busy)
				track_reg <= din;

			if (sector_inc)
				sector_reg <= sector_reg + 8'd1;   // multi-sector advance
			else if (wr && (addr == `FDC_A_SECTOR) && !busy)
				sector_reg <= din;

			if (wr && (addr == `FDC_A_DATA))
				data_reg <= din;   // seek target, always taken
		end
	end

	always_comb begin
		case (addr)
			`FDC_A_CMD:    dout = status;
			`FDC_A_TRACK:  dout = track_reg;
			`FDC_A_SECTOR: dout = sector_reg;
			default:       dout = xfer ? buff_din : data_reg;   // image byte during a read
		endcase
	end

endmodule

//--- hdl/fdc_engine.sv
// ========================================
// command engine
// runs type I, read sector, write fault and
// force interrupt, keeps head position and
// builds the status byte
// ========================================
`timescale 1ns/1ns
`include "fdc_macros.svh"

module fdc_engine (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic [7:0]             din,
	input  logic                   cmd_wr,
	input  logic                   status_rd,
	input  logic                   data_rd,
	input  logic                   ready,
	input  logic [7:0]             data_reg,
	input  logic [7:0]             sector_reg,
	input  logic [7:0]             sectors_per_track,
	input  logic [`FDC_LEN_W-1:0]  sector_bytes,
	output logic [7:0]             head_track,
	output logic [`FDC_LEN_W-1:0]  byte_index,
	output logic                   track_set,
	output logic [7:0]             track_value,
	output logic                   sector_inc,
	output fdc_pkg::fdc_status_u   status,
	output logic                   drq,
	output logic                   busy,
	output logic                   intrq,
	output logic                   xfer,
	output logic                   buff_read
);

	localparam logic [`FDC_DLY_W-1:0] SETTLE_DLY = `FDC_DLY_W'(`FDC_SETTLE_CYCLES);
	localparam logic [`FDC_DLY_W-1:0] SEARCH_DLY = `FDC_DLY_W'(`FDC_SEARCH_CYCLES);
	localparam logic [`FDC_DLY_W-1:0] GAP_DLY    = `FDC_DLY_W'(`FDC_BYTE_GAP);

	fdc_pkg::fdc_state_e      state;
	logic [`FDC_DLY_W-1:0]    delay;
	logic                     step_dir;      // 1 = out, towards track 0
	logic                     cmd_class;     // 0 = type I status view
	logic                     wpe;           // write protect shown in status
	logic                     head_loaded;
	logic                     seek_err;      // also record not found
	logic                     write_fault;
	logic                     multi;

	wire       accept     = (state == fdc_pkg::ST_IDLE) || (din[7:4] == 4'hD);
	wire       step_out   = din[6] ? din[5] : step_dir;
	wire [7:0] next_track = step_out ? head_track - 8'd1 : head_track + 8'd1;
	wire       last_byte  = (byte_index == sector_bytes - 11'd1);

	assign buff_read = xfer;

	// ========================================
	// status byte, two views of one word
	// ========================================
	always_comb begin
		status = '0;
		if (!cmd_class) begin
			status.t1.not_ready   = ~ready;
			status.t1.write_prot  = wpe;   // image is always read only
			status.t1.head_loaded = head_loaded;
			status.t1.seek_err    = seek_err | ~ready;
			status.t1.track0      = (head_track == 8'd0);
			status.t1.busy        = busy;
		end else begin
			status.t2.not_ready     = ~ready;
			status.t2.write_prot    = wpe;
			status.t2.write_fault   = write_fault;
			status.t2.rec_not_found = seek_err | ~ready;
			status.t2.drq           = drq;
			status.t2.busy          = busy;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= fdc_pkg::ST_IDLE;
			delay <= '0;
			{step_dir, cmd_class, head_loaded, seek_err, write_fault, multi} <= '0;
			wpe <= 1'b1;
			head_track <= 8'd0;
			byte_index <= '0;
			{track_set, sector_inc, drq, busy, intrq, xfer} <= '0;
			track_value <= 8'd0;
		end else begin
			track_set  <= 1'b0;
			sector_inc <= 1'b0;
			if (status_rd)
				intrq <= 1'b0;

			case (state)
				fdc_pkg::ST_SETTLE: begin
					if (delay == '0) state <= fdc_pkg::ST_END;
					else delay <= delay - 1'b1;
				end
				fdc_pkg::ST_SEARCH: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state <= fdc_pkg::ST_END;
					end else if (delay != '0) begin
						delay <= delay - 1'b1;
					end else if (sector_reg == 8'd0 || sector_reg > sectors_per_track) begin
						seek_err <= 1'b1;   // record not found
						state <= fdc_pkg::ST_END;
					end else begin
						byte_index <= '0;
						xfer <= 1'b1;
						delay <= GAP_DLY;
						state <= fdc_pkg::ST_GAP;
					end
				end
				fdc_pkg::ST_GAP: begin
					if (delay == '0) begin
						drq <= 1'b1;
						state <= fdc_pkg::ST_DRQ;
					end else begin
						delay <= delay - 1'b1;
					end
				end
				fdc_pkg::ST_DRQ: if (data_rd) begin   // holds until the host reads
					drq <= 1'b0;
					if (!last_byte) begin
						byte_index <= byte_index + 11'd1;
						delay <= GAP_DLY;
						state <= fdc_pkg::ST_GAP;
					end else if (multi) begin
						xfer <= 1'b0;
						sector_inc <= 1'b1;
						delay <= SEARCH_DLY;
						state <= fdc_pkg::ST_SEARCH;
					end else begin
						state <= fdc_pkg::ST_END;
					end
				end
				fdc_pkg::ST_ABORT: begin
					{seek_err, write_fault} <= 2'b00;
					{drq, xfer} <= 2'b00;
					state <= fdc_pkg::ST_END;
				end
				fdc_pkg::ST_END: begin
					{drq, busy, xfer} <= 3'b000;
					intrq <= 1'b1;
					state <= fdc_pkg::ST_IDLE;
				end
				default: ;   // idle
			endcase

			// ========================================
			// command decode
			// ========================================
			if (cmd_wr) begin
				intrq <= 1'b0;
				if (accept) begin
					cmd_class <= din[7];
					wpe <= ~din[7];
					case (din[7:4])
						4'h0: begin   // restore
							head_track <= 8'd0;
							track_value <= 8'd0;
							track_set <= 1'b1;
							head_loaded <= din[3];
							busy <= 1'b1;
							delay <= SETTLE_DLY;
							state <= fdc_pkg::ST_SETTLE;
						end
						4'h1: begin   // seek, track register untouched
							head_track <= data_reg;
							head_loaded <= din[3];
							busy <= 1'b1;
							delay <= SETTLE_DLY;
							state <= fdc_pkg::ST_SETTLE;
						end
						4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
							if (din[6]) step_dir <= din[5];
							head_track <= next_track;
							if (din[4]) begin   // update variants
								track_value <= next_track;
								track_set <= 1'b1;
							end
							head_loaded <= din[3];
							busy <= 1'b1;
							delay <= SETTLE_DLY;
							state <= fdc_pkg::ST_SETTLE;
						end
						4'h8, 4'h9: begin   // read sector
							{seek_err, write_fault} <= 2'b00;
							multi <= din[4];
							wpe <= din[5];
							byte_index <= '0;
							busy <= 1'b1;
							delay <= SEARCH_DLY;
							state <= fdc_pkg::ST_SEARCH;
						end
						4'hA, 4'hB: begin   // write sector, image is read only
							seek_err <= 1'b0;
							write_fault <= 1'b1;
							wpe <= 1'b1;
							busy <= 1'b1;
							delay <= SETTLE_DLY;
							state <= fdc_pkg::ST_SETTLE;
						end
						4'hD: begin   // force interrupt
							cmd_class <= 1'b0;
							if (state != fdc_pkg::ST_IDLE)
								state <= fdc_pkg::ST_ABORT;
							else
								{seek_err, write_fault, drq, busy} <= 4'b0000;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- hdl/fdc_top.sv
// ========================================
// floppy controller top
// host registers, command engine and image
// geometry for a flat read-only disk image
// ========================================
`timescale 1ns/1ns
`include "fdc_macros.svh"

module fdc_top (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   rd,
	input  logic                   wr,
	input  logic [1:0]             addr,
	input  logic [7:0]             din,
	output logic [7:0]             dout,
	output logic                   drq,
	output logic                   intrq,
	output logic                   busy,
	input  logic [2:0]             size_code,
	input  logic                   side,
	input  logic                   ready,
	output logic [`FDC_IMG_AW-1:0] buff_addr,
	output logic                   buff_read,
	input  logic [7:0]             buff_din
);

	// register block to engine
	logic                    cmd_wr;
	logic                    status_rd;
	logic                    data_rd;
	logic [7:0]              sector_reg;
	logic [7:0]              data_reg;

	// engine to register block
	logic                    track_set;
	logic [7:0]              track_value;
	logic                    sector_inc;
	logic                    xfer;
	fdc_pkg::fdc_status_u    status;

	// geometry
	logic [7:0]              head_track;
	logic [`FDC_LEN_W-1:0]   byte_index;
	logic [7:0]              sectors_per_track;
	logic [`FDC_LEN_W-1:0]   sector_bytes;

	fdc_regs regs_inst (
		.clk_sys, .rst_n, .rd, .wr, .addr, .din, .busy, .status, .xfer, .buff_din,
		.track_set, .track_value, .sector_inc, .dout, .cmd_wr, .status_rd, .data_rd,
		.track_reg(), .sector_reg, .data_reg
	);

	fdc_engine engine_inst (
		.clk_sys, .rst_n, .din, .cmd_wr, .status_rd, .data_rd, .ready, .data_reg,
		.sector_reg, .sectors_per_track, .sector_bytes, .head_track, .byte_index,
		.track_set, .track_value, .sector_inc, .status, .drq, .busy, .intrq, .xfer,
		.buff_read
	);

	fdc_geometry geometry_inst (
		.size_code, .head_track, .side, .sector(sector_reg), .byte_index,
		.buff_addr, .sectors_per_track, .sector_bytes
	);

endmodule

//--- tb/fdc_tb.sv
// ========================================
// floppy controller testbench
// random type I, read sector, error and
// force interrupt runs against a model of
// head, registers and image geometry
// ========================================
`timescale 1ns/1ns
`include "fdc_macros.svh"

module fdc_tb;

	localparam int WAIT_LIMIT = 2000;   // cycles per wait

	logic                    clk_sys = 1'b0;
	logic                    rst_n;
	logic                    rd;
	logic                    wr;
	logic [1:0]              addr;
	logic [7:0]              din;
	logic [7:0]              dout;
	logic                    drq;
	logic                    intrq;
	logic                    busy;
	logic [2:0]              size_code;
	logic                    side;
	logic                    ready;
	logic [`FDC_IMG_AW-1:0]  buff_addr;
	logic                    buff_read;
	logic [7:0]              buff_din;

	int errors = 0;
	int checks = 0;
	int timeouts = 0;

	// model state
	logic [7:0] m_head;
	logic [7:0] m_track;
	logic [7:0] m_data;
	logic       m_dir;   // 1 = out, towards track 0

	fdc_top fdc_top_inst (.*);

	always #4 clk_sys = ~clk_sys;

	// image pattern over the whole address
	function automatic logic [7:0] image_byte(input logic [19:0] a);
		return a[7:0] ^ a[15:8] ^ {4'd0, a[19:16]};
	endfunction

	assign buff_din = image_byte(buff_addr);

	// ========================================
	// geometry model
	// ========================================
	function automatic int sec_per_track(input logic [2:0] code);
		case (code)
			3'd1: return 16;
			3'd2: return 9;
			3'd3: return 5;
			3'd4: return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int sec_bytes(input logic [2:0] code);
		case (code)
			3'd1: return 256;
			3'd2: return 512;
			3'd3: return 1024;
			3'd4: return 512;
			default: return 128;
		endcase
	endfunction

	function automatic logic [19:0] model_addr(input logic [2:0] code, input int head,
			input int sd, input int sec, input int idx);
		int lt;
		int bps;
		lt = 2 * head + sd;
		bps = sec_bytes(code);
		return 20'(lt * sec_per_track(code) * bps + (sec - 1) * bps + idx);
	endfunction

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		wr = 1'b1;
		addr = a;
		din = d;
		@(negedge clk_sys);
		wr = 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		@(negedge clk_sys);
		rd = 1'b1;
		addr = a;
		#2 d = dout;   // before the strobe edge moves the byte index
		@(negedge clk_sys);
		rd = 1'b0;
	endtask

	task automatic wait_busy_low(input string name);
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (busy) begin
			errors++;
			timeouts++;
			$display("%s: busy still high after %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	task automatic wait_drq(input string name);
		int n;
		n = 0;
		while (!drq && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!drq) begin
			errors++;
			timeouts++;
			$display("%s: no data request within %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	task automatic run_cmd(input string name, input logic [7:0] c);
		bus_write(`FDC_A_CMD, c);
		wait_busy_low(name);
	endtask

	task automatic seek_to(input logic [7:0] h);
		m_data = h;
		bus_write(`FDC_A_DATA, h);
		run_cmd("seek", 8'h10);
		m_head = h;
	endtask

	// one sector from the data register, checked byte by byte
	task automatic read_bytes(input string name, input int sec);
		logic [7:0] v;
		int nb;
		nb = sec_bytes(size_code);
		for (int i = 0; i < nb; i++) begin
			wait_drq(name);
			if (timeouts != 0)
				break;
			check({name, " buff_read"}, 1, buff_read);
			check({name, " address"}, model_addr(size_code, m_head, side, sec, i),
				buff_addr);
			bus_read(`FDC_A_DATA, v);
			check(name, image_byte(model_addr(size_code, m_head, side, sec, i)), v);
		end
	endtask

	initial begin
		logic [7:0] v;
		logic [7:0] c;
		logic       out_dir;
		int         spt;
		int         sec;
		int         seed;
		seed = $urandom(70);
		rst_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = 2'd0;
		din = 8'd0;
		size_code = 3'd0;
		side = 1'b0;
		ready = 1'b1;
		m_head = 8'd0;
		m_track = 8'd0;
		m_data = 8'd0;
		m_dir = 1'b0;
		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;

		// ========================================
		// reset state
		// ========================================
		bus_read(`FDC_A_CMD, v);
		check("reset status", 8'h44, v);   // write protect, track 0
		check("reset drq", 0, drq);
		check("reset busy", 0, busy);
		check("reset intrq", 0, intrq);
		check("reset buff_read", 0, buff_read);
		bus_read(`FDC_A_TRACK, v);
		check("reset track", 0, v);
		bus_read(`FDC_A_SECTOR, v);
		check("reset sector", 0, v);

		// type I commands
		for (int n = 0; n < 30; n++) begin
			c = 8'($urandom % 128);
			if (c[7:4] == 4'h1) begin
				m_data = 8'($urandom);
				bus_write(`FDC_A_DATA, m_data);
			end
			out_dir = c[6] ? c[5] : m_dir;
			if (c[7:5] != 3'd0 && ((out_dir && m_head == 8'd0) || (!out_dir && m_head == 8'hFF)))
				c = {4'h0, c[3:0]};   // no step past either end, restore instead
			case (c[7:4])
				4'h0: begin
					m_head = 8'd0;
					m_track = 8'd0;
				end
				4'h1: m_head = m_data;
				default: begin
					if (c[6])
						m_dir = c[5];
					m_head = m_dir ? m_head - 8'd1 : m_head + 8'd1;
					if (c[4])
						m_track = m_head;
				end
			endcase
			run_cmd("type I", c);
			check("type I intrq", 1, intrq);
			bus_read(`FDC_A_TRACK, v);
			check("type I track", m_track, v);
			bus_read(`FDC_A_CMD, v);
			check("type I head loaded", c[3], v[5]);
			check("type I track 0", m_head == 8'd0, v[2]);
			check("type I intrq clear", 0, intrq);
		end

		// ========================================
		// single sector reads
		// ========================================
		for (int n = 0; n < 4; n++) begin
			@(negedge clk_sys);
			size_code = 3'($urandom % 5);
			side = 1'($urandom);
			seek_to(8'($urandom % 80));
			spt = sec_per_track(size_code);
			sec = 1 + int'($urandom % spt);
			bus_write(`FDC_A_SECTOR, 8'(sec));
			bus_write(`FDC_A_CMD, 8'h80);
			read_bytes("single read", sec);
			wait_busy_low("single read");
			check("single read intrq", 1, intrq);
			bus_read(`FDC_A_CMD, v);
			check("single read status", 8'h00, v);
		end

		// multi sector read to the end of the track
		@(negedge clk_sys);
		size_code = 3'($urandom % 5);
		side = 1'($urandom);
		seek_to(8'($urandom % 80));
		spt = sec_per_track(size_code);
		sec = spt - int'($urandom % 2);
		bus_write(`FDC_A_SECTOR, 8'(sec));
		bus_write(`FDC_A_CMD, 8'h90);
		for (int s = sec; s <= spt; s++)
			read_bytes("multi read", s);
		wait_busy_low("multi read");
		check("multi read intrq", 1, intrq);
		bus_read(`FDC_A_SECTOR, v);
		check("multi read sector", spt + 1, v);
		bus_read(`FDC_A_CMD, v);
		check("multi read status", 8'h10, v);   // record not found

		// ========================================
		// error paths
		// ========================================
		bus_write(`FDC_A_SECTOR, 8'd0);
		run_cmd("sector 0", 8'h80);
		bus_read(`FDC_A_CMD, v);
		check("sector 0 status", 8'h10, v);

		@(negedge clk_sys);
		ready = 1'b0;
		bus_write(`FDC_A_SECTOR, 8'd1);
		run_cmd("not ready", 8'h80);
		bus_read(`FDC_A_CMD, v);
		check("not ready status", 8'h90, v);
		@(negedge clk_sys);
		ready = 1'b1;

		run_cmd("write sector", 8'hA0);
		bus_read(`FDC_A_CMD, v);
		check("write sector status", 8'h60, v);   // write protect, write fault

		m_data = m_head;
		bus_write(`FDC_A_DATA, m_head);
		bus_write(`FDC_A_CMD, 8'h10);
		bus_write(`FDC_A_TRACK, m_track ^ 8'h5A);   // lands while busy
		wait_busy_low("track write busy");
		bus_read(`FDC_A_TRACK, v);
		check("track write busy", m_track, v);

		// force interrupt during a read
		@(negedge clk_sys);
		size_code = 3'($urandom % 5);
		seek_to(8'($urandom % 80));
		bus_write(`FDC_A_SECTOR, 8'd1);
		bus_write(`FDC_A_CMD, 8'h80);
		wait_drq("force interrupt");
		bus_write(`FDC_A_CMD, 8'hD0);
		wait_busy_low("force interrupt");
		check("force interrupt drq", 0, drq);
		check("force interrupt intrq", 1, intrq);
		bus_read(`FDC_A_CMD, v);
		check("force interrupt errors", 0, v & 8'h99);

		bus_write(`FDC_A_CMD, 8'hD0);   // idle now
		repeat (4) @(negedge clk_sys);
		check("idle force interrupt intrq", 0, intrq);
		check("idle force interrupt busy", 0, busy);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hdl
hdl/fdc_pkg.sv
hdl/fdc_geometry.sv
hdl/fdc_regs.sv
hdl/fdc_engine.sv
hdl/fdc_top.sv
tb/fdc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the floppy controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fdc_tb \
	-f verilog.f -o fdc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/fdc_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1
